/* sim.f */
hw/vga_pkg.sv
hw/pixel_pos_if.sv
hw/vga_sync.sv
hw/debug_text.sv
hw/map_tile.sv
hw/char_sprite.sv
hw/pixel_gen.sv
hw/video_top.sv
tests/video_tb.sv

/* Bender.yml */
package:
  name: vga_video

sources:
  # RTL in compile order
  - files:
      - hw/vga_pkg.sv
      - hw/pixel_pos_if.sv
      - hw/vga_sync.sv
      - hw/debug_text.sv
      - hw/map_tile.sv
      - hw/char_sprite.sv
      - hw/pixel_gen.sv
      - hw/video_top.sv

  # Testbench
  - target: simulation
    files:
      - tests/video_tb.sv

/* tests/video_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module video_tb
    import vga_pkg::*;
();

    localparam int CLK_PERIOD = 100; // ns

    // 640x480 mode
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Layer geometry
    localparam int SEQ_NUM    = 16;
    localparam int SEQ_DIGITS = 4;
    localparam int MAP_X      = 270;
    localparam int MAP_Y      = 50;
    localparam int MAP_W      = 100;
    localparam int MAP_H      = 100;
    localparam int TILE       = 10;
    localparam int CHAR_W     = 32;
    localparam int CHAR_H     = 32;
    localparam int BORDER     = 2;  // Sprite edge thickness

    localparam int FRAMES       = 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_NS  = 3 * FRAME_CYCLES * CLK_PERIOD;

    typedef logic [SEQ_NUM-1:0][SEQ_DIGITS*4-1:0] words_t;

    logic   sys_clk;
    logic   rst;
    words_t debug_words;
    coord_t char_x;
    coord_t char_y;
    color_t rgb;
    logic   hsync;
    logic   vsync;

    // Model state
    logic [31:0] rand_state;
    words_t      frame_words; // Values the DUT sees in the current frame
    int          frame_cx;
    int          frame_cy;
    words_t      next_words;  // Values for the coming frame
    int          next_cx;
    int          next_cy;
    int          cur_frame;   // -1 while in reset
    int          cur_x;
    int          cur_y;

    video_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .SEQ_NUM (SEQ_NUM), .SEQ_DIGITS (SEQ_DIGITS),
        .MAP_X (MAP_X), .MAP_Y (MAP_Y), .MAP_W (MAP_W), .MAP_H (MAP_H), .TILE (TILE),
        .CHAR_W (CHAR_W), .CHAR_H (CHAR_H)
    ) video_top_inst (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .debug_words (debug_words),
        .char_x      (char_x),
        .char_y      (char_y),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    //----------------------------------------
    // Random numbers and stimulus
    //----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rand_state = xorshift32(rand_state);
        value      = rand_state;
    endtask

    // New words and sprite spot for one frame
    task automatic pick_frame_inputs(input int frame);
        logic [31:0] r;
        for (int k = 0; k < SEQ_NUM; k++) begin
            draw_random(r);
            next_words[k] = r[SEQ_DIGITS*4-1:0];
        end
        draw_random(r);
        if (frame % 2 == 0) begin
            next_cx = MAP_X - 24 + int'(r[3:0]);      // Straddles left map edge
            next_cy = MAP_Y + 4 * int'(r[7:4]);
        end else begin
            next_cx = 16 + int'(r[3:0]);              // Overlaps text columns
            next_cy = int'(r[15:8]) % 180;            // Shows through row gaps
        end
    endtask

    task automatic apply_frame_inputs();
        debug_words <= next_words;
        char_x      <= coord_t'(next_cx);
        char_y      <= coord_t'(next_cy);
    endtask

    //----------------------------------------
    // Reference model
    //----------------------------------------
    function automatic color_t expected_rgb(input int x, input int y, input words_t words,
                                            input int cx, input int cy);
        int         row;
        int         line;
        int         digit;
        logic [3:0] nib;
        int         dx;
        int         dy;
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            return BLACK; // Blanking
        end
        row = -1;
        for (int k = 0; k < SEQ_NUM; k++) begin // First matching row wins
            if (row < 0 && y >= k * (FONT_W + ROW_GAP) && y < k * (FONT_W + ROW_GAP) + FONT_W) begin
                row = k;
            end
        end
        if (row >= 0 && x < SEQ_DIGITS * FONT_W) begin
            line  = y - row * (FONT_W + ROW_GAP);
            digit = x / FONT_W;
            nib   = words[row][(SEQ_DIGITS - 1 - digit) * 4 +: 4]; // Leftmost digit is MSB
            if (hex_glyph[nib][line][7 - (x % FONT_W)]) begin
                return TEXT_FG;
            end
            return TEXT_BG;
        end
        if (x >= MAP_X && x < MAP_X + MAP_W && y >= MAP_Y && y < MAP_Y + MAP_H) begin
            if ((((x - MAP_X) / TILE + (y - MAP_Y) / TILE) % 2) == 0) begin
                return MAP_A;
            end
            return MAP_B;
        end
        if (x >= cx && x < cx + CHAR_W && y >= cy && y < cy + CHAR_H) begin
            dx = x - cx;
            dy = y - cy;
            if (dx < BORDER || dx >= CHAR_W - BORDER || dy < BORDER || dy >= CHAR_H - BORDER) begin
                return CHAR_EDGE;
            end
            return CHAR_BODY;
        end
        return WHITE;
    endfunction

    //----------------------------------------
    // Checks
    //----------------------------------------
    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            if (cur_frame < 0) begin
                $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h during reset",
                         name, actual, expected);
            end else begin
                $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at frame %0d x=%0d y=%0d",
                         name, actual, expected, cur_frame, cur_x, cur_y);
            end
            $display("Verification failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_reset_outputs();
        compare_value("rgb", rgb, BLACK);
        compare_value("hsync", hsync, 1'b1); // Inactive level
        compare_value("vsync", vsync, 1'b1);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        rand_state  = 32'd53;
        cur_frame   = -1;
        cur_x       = 0;
        cur_y       = 0;
        rst         = 1'b1;
        debug_words = '0;
        char_x      = '0;
        char_y      = '0;

        @(posedge sys_clk);
        @(negedge sys_clk);
        check_reset_outputs();
        @(posedge sys_clk);  // Second reset edge, release here
        pick_frame_inputs(0);
        rst <= 1'b0;
        apply_frame_inputs();
        @(negedge sys_clk);
        check_reset_outputs();

        for (int f = 0; f < FRAMES; f++) begin
            frame_words = next_words;
            frame_cx    = next_cx;
            frame_cy    = next_cy;
            for (int y = 0; y < V_TOTAL; y++) begin
                for (int x = 0; x < H_TOTAL; x++) begin
                    @(posedge sys_clk); // Registers pixel x,y
                    if (x == H_TOTAL - 1 && y == V_TOTAL - 1) begin
                        pick_frame_inputs(f + 1); // Seen from the next frame's first pixel
                        apply_frame_inputs();
                    end
                    @(negedge sys_clk);
                    cur_frame = f;
                    cur_x     = x;
                    cur_y     = y;
                    compare_value("rgb", rgb,
                                  expected_rgb(x, y, frame_words, frame_cx, frame_cy));
                    compare_value("hsync", hsync,
                        !(x >= H_ACTIVE + H_FRONT && x < H_ACTIVE + H_FRONT + H_SYNC));
                    compare_value("vsync", vsync,
                        !(y >= V_ACTIVE + V_FRONT && y < V_ACTIVE + V_FRONT + V_SYNC));
                end
            end
        end

        $display("Verification passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within three frame times");
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* hw/video_top.sv */
`timescale 1ns/1ns
`default_nettype none

module video_top
    import vga_pkg::*;
#(
    parameter int H_ACTIVE   = 640, // Horizontal mode
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_ACTIVE   = 480, // Vertical mode
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int SEQ_NUM    = 16,  // Debug rows
    parameter int SEQ_DIGITS = 4,   // Hex digits per row
    parameter int MAP_X      = 270,
    parameter int MAP_Y      = 50,
    parameter int MAP_W      = 100,
    parameter int MAP_H      = 100,
    parameter int TILE       = 10,
    parameter int CHAR_W     = 32,
    parameter int CHAR_H     = 32
) (
    input  logic   sys_clk, // Pixel clock
    input  logic   rst,
    input  logic [SEQ_NUM-1:0][SEQ_DIGITS*4-1:0] debug_words,
    input  coord_t char_x,
    input  coord_t char_y,
    output color_t rgb,
    output logic   hsync,
    output logic   vsync
);

    pixel_pos_if pos ();

    vga_sync #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_sync_inst (
        .sys_clk (sys_clk),
        .rst     (rst),
        .pos     (pos.src)
    );

    pixel_gen #(
        .SEQ_NUM    (SEQ_NUM),
        .SEQ_DIGITS (SEQ_DIGITS),
        .MAP_X      (MAP_X),
        .MAP_Y      (MAP_Y),
        .MAP_W      (MAP_W),
        .MAP_H      (MAP_H),
        .TILE       (TILE),
        .CHAR_W     (CHAR_W),
        .CHAR_H     (CHAR_H)
    ) pixel_gen_inst (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .pos         (pos.sink),
        .debug_words (debug_words),
        .char_x      (char_x),
        .char_y      (char_y),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

endmodule

`default_nettype wire

/* hw/pixel_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_gen
    import vga_pkg::*;
#(
    parameter int SEQ_NUM    = 16,
    parameter int SEQ_DIGITS = 4,
    parameter int MAP_X      = 270,
    parameter int MAP_Y      = 50,
    parameter int MAP_W      = 100,
    parameter int MAP_H      = 100,
    parameter int TILE       = 10,
    parameter int CHAR_W     = 32,
    parameter int CHAR_H     = 32
) (
    input  logic   sys_clk,
    input  logic   rst,
    pixel_pos_if.sink pos,
    input  logic [SEQ_NUM-1:0][SEQ_DIGITS*4-1:0] debug_words,
    input  coord_t char_x,
    input  coord_t char_y,
    output color_t rgb,
    output logic   hsync,
    output logic   vsync
);

    logic   text_hit;
    logic   map_hit;
    logic   char_hit;
    color_t text_color;
    color_t map_color;
    color_t char_color;
    color_t pix_color; // Chosen colour before the output register

    //----------------------------------------
    // Layers
    //----------------------------------------
    debug_text #(
        .SEQ_NUM    (SEQ_NUM),
        .SEQ_DIGITS (SEQ_DIGITS)
    ) debug_text_inst (
        .x           (pos.x),
        .y           (pos.y),
        .debug_words (debug_words),
        .hit         (text_hit),
        .color       (text_color)
    );

    map_tile #(
        .MAP_X (MAP_X),
        .MAP_Y (MAP_Y),
        .MAP_W (MAP_W),
        .MAP_H (MAP_H),
        .TILE  (TILE)
    ) map_tile_inst (
        .x     (pos.x),
        .y     (pos.y),
        .hit   (map_hit),
        .color (map_color)
    );

    char_sprite #(
        .CHAR_W (CHAR_W),
        .CHAR_H (CHAR_H)
    ) char_sprite_inst (
        .x      (pos.x),
        .y      (pos.y),
        .char_x (char_x),
        .char_y (char_y),
        .hit    (char_hit),
        .color  (char_color)
    );

    //----------------------------------------
    // Priority and blanking
    //----------------------------------------
    always_comb begin
        if (!pos.video_on) begin
            pix_color = BLACK;      // Porches and sync
        end else if (text_hit) begin
            pix_color = text_color; // Text over everything
        end else if (map_hit) begin
            pix_color = map_color;
        end else if (char_hit) begin
            pix_color = char_color; // Sprite sits behind the map
        end else begin
            pix_color = WHITE;
        end
    end

    // One clock of latency on colour and syncs alike
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            rgb   <= BLACK;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= pix_color;
            hsync <= pos.hsync;
            vsync <= pos.vsync;
        end
    end

endmodule

`default_nettype wire

/* hw/char_sprite.sv */
`timescale 1ns/1ns
`default_nettype none

module char_sprite
    import vga_pkg::*;
#(
    parameter int CHAR_W = 32,
    parameter int CHAR_H = 32
) (
    input  coord_t x,
    input  coord_t y,
    input  coord_t char_x, // Top left corner of the box
    input  coord_t char_y,
    output logic   hit,
    output color_t color
);

    localparam int EDGE = 2; // Border thickness

    coord_t dx; // Offset inside the box
    coord_t dy;
    logic   on_edge;

    // Right and bottom bounds are wide sums so no wrap at the screen end
    assign hit = (x >= char_x) && (x < char_x + CHAR_W) &&
                 (y >= char_y) && (y < char_y + CHAR_H);

    assign dx = x - char_x;
    assign dy = y - char_y;

    // Outer ring of the box
    assign on_edge = (dx < EDGE) || (dx >= CHAR_W - EDGE) ||
                     (dy < EDGE) || (dy >= CHAR_H - EDGE);

    assign color = on_edge ? CHAR_EDGE : CHAR_BODY;

endmodule

`default_nettype wire

/* hw/map_tile.sv */
`timescale 1ns/1ns
`default_nettype none

module map_tile
    import vga_pkg::*;
#(
    parameter int MAP_X = 270, // Window origin
    parameter int MAP_Y = 50,
    parameter int MAP_W = 100, // Window size
    parameter int MAP_H = 100,
    parameter int TILE  = 10   // Checker square size
) (
    input  coord_t x,
    input  coord_t y,
    output logic   hit,
    output color_t color
);

    coord_t dx; // Offset inside the window
    coord_t dy;
    coord_t tile_col;
    coord_t tile_row;
    coord_t tile_sum;

    assign hit = (x >= MAP_X) && (x < MAP_X + MAP_W) &&
                 (y >= MAP_Y) && (y < MAP_Y + MAP_H);

    assign dx = x - coord_t'(MAP_X);
    assign dy = y - coord_t'(MAP_Y);

    // Tile indices
    assign tile_col = coord_t'(dx / TILE);
    assign tile_row = coord_t'(dy / TILE);
    assign tile_sum = tile_col + tile_row;

    assign color = tile_sum[0] ? MAP_B : MAP_A; // Even sum is MAP_A

endmodule

`default_nettype wire

/* hw/debug_text.sv */
`timescale 1ns/1ns
`default_nettype none

module debug_text
    import vga_pkg::*;
#(
    parameter int SEQ_NUM    = 16,
    parameter int SEQ_DIGITS = 4
) (
    input  coord_t x,
    input  coord_t y,
    input  logic [SEQ_NUM-1:0][SEQ_DIGITS*4-1:0] debug_words,
    output logic   hit,
    output color_t color
);

    localparam int ROW_PITCH = FONT_W + ROW_GAP; // Lines from one row top to the next
    localparam int TEXT_W    = SEQ_DIGITS * FONT_W;

    logic                    row_hit;
    logic                    col_hit;
    logic [SEQ_DIGITS*4-1:0] word;       // Word of the selected row
    logic [2:0]              glyph_line; // Line within the glyph
    logic [2:0]              glyph_col;  // Column within the glyph
    logic [3:0]              nibble;
    int                      digit;

    //----------------------------------------
    // Row select
    //----------------------------------------
    // Scan from the top row down so the lowest index wins on overlap
    always_comb begin
        row_hit    = 1'b0;
        word       = '0;
        glyph_line = '0;
        for (int k = SEQ_NUM - 1; k >= 0; k--) begin
            if ((int'(y) >= k * ROW_PITCH) && (int'(y) < k * ROW_PITCH + FONT_W)) begin
                row_hit    = 1'b1;
                word       = debug_words[k];
                glyph_line = 3'(int'(y) - k * ROW_PITCH);
            end
        end
    end

    assign col_hit = (int'(x) < TEXT_W); // Text starts at the left edge

    //----------------------------------------
    // Digit and glyph lookup
    //----------------------------------------
    always_comb begin
        digit     = int'(x) / FONT_W;
        glyph_col = 3'(int'(x) % FONT_W);
        nibble    = '0;
        if (col_hit) begin
            nibble = word[(SEQ_DIGITS - 1 - digit) * 4 +: 4]; // Digit 0 is the top nibble
        end
    end

    assign hit = row_hit && col_hit;

    // Set glyph bit is foreground
    assign color = hex_glyph[nibble][glyph_line][3'd7 - glyph_col] ? TEXT_FG : TEXT_BG;

endmodule

`default_nettype wire

/* hw/vga_sync.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_sync
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic sys_clk,
    input  logic rst,
    pixel_pos_if.src pos
);

    // Line and frame totals
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Sync pulse windows
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    coord_t x_cnt;
    coord_t y_cnt;
    coord_t x_next;
    coord_t y_next;
    logic   hsync_q;
    logic   vsync_q;
    logic   video_on_q;

    //----------------------------------------
    // Next position
    //----------------------------------------
    always_comb begin
        x_next = x_cnt + 1'b1;
        y_next = y_cnt;
        if (x_cnt == coord_t'(H_TOTAL - 1)) begin // End of line
            x_next = '0;
            if (y_cnt == coord_t'(V_TOTAL - 1)) begin
                y_next = '0; // End of frame
            end else begin
                y_next = y_cnt + 1'b1;
            end
        end
    end

    // Syncs and active flag follow the next position so all stay aligned
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            x_cnt      <= '0;
            y_cnt      <= '0;
            hsync_q    <= 1'b1; // Inactive
            vsync_q    <= 1'b1;
            video_on_q <= 1'b1; // Position 0,0 is visible
        end else begin
            x_cnt      <= x_next;
            y_cnt      <= y_next;
            hsync_q    <= !((x_next >= H_SYNC_START) && (x_next < H_SYNC_END));
            vsync_q    <= !((y_next >= V_SYNC_START) && (y_next < V_SYNC_END));
            video_on_q <= (x_next < H_ACTIVE) && (y_next < V_ACTIVE);
        end
    end

    assign pos.x        = x_cnt;
    assign pos.y        = y_cnt;
    assign pos.hsync    = hsync_q;
    assign pos.vsync    = vsync_q;
    assign pos.video_on = video_on_q;

endmodule

`default_nettype wire

/* hw/pixel_pos_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Pixel position and syncs, one value per pixel clock
interface pixel_pos_if
    import vga_pkg::*;
();

    coord_t x;        // Horizontal counter
    coord_t y;        // Vertical counter
    logic   video_on; // Inside the visible area
    logic   hsync;    // Active low
    logic   vsync;    // Active low

    // Sync generator side
    modport src (
        output x, y, video_on, hsync, vsync
    );

    // Pixel generator side
    modport sink (
        input x, y, video_on, hsync, vsync
    );

endinterface

`default_nettype wire

/* hw/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    typedef logic [11:0] color_t; // 4 bits per channel
    typedef logic [9:0]  coord_t; // Covers an 800 pixel line total

    //----------------------------------------
    // Palette
    //----------------------------------------
    localparam color_t WHITE     = 12'hFFF; // Background
    localparam color_t BLACK     = 12'h000; // Blanking
    localparam color_t TEXT_FG   = 12'h7F7;
    localparam color_t TEXT_BG   = 12'h222;
    localparam color_t MAP_A     = 12'h2A6; // Even checker tiles
    localparam color_t MAP_B     = 12'h820; // Odd checker tiles
    localparam color_t CHAR_EDGE = 12'hA21;
    localparam color_t CHAR_BODY = 12'hF80;

    // Debug text geometry
    localparam int FONT_W  = 8; // Glyph width and height in pixels
    localparam int ROW_GAP = 5; // Blank lines between text rows

    //----------------------------------------
    // Hex font, 8x8, MSB is leftmost pixel
    //----------------------------------------
    localparam logic [7:0] hex_glyph [16][8] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00}, // 0
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00}, // 1
        '{8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E, 8'h00}, // 2
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00}, // 3
        '{8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'h7E, 8'h0C, 8'h0C, 8'h00}, // 4
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00}, // 5
        '{8'h3C, 8'h60, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00}, // 6
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00}, // 7
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00}, // 8
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h0C, 8'h38, 8'h00}, // 9
        '{8'h18, 8'h3C, 8'h66, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h00}, // A
        '{8'h7C, 8'h66, 8'h66, 8'h7C, 8'h66, 8'h66, 8'h7C, 8'h00}, // B
        '{8'h3C, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3C, 8'h00}, // C
        '{8'h78, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h6C, 8'h78, 8'h00}, // D
        '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h7E, 8'h00}, // E
        '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h60, 8'h00}  // F
    };

endpackage

`default_nettype wire
